// File: dmm_reg_pkg.sv
// register map, spi frame layout and register widths
// sequence word types shared by the register bank and the sequencer
`default_nettype none

package dmm_reg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  localparam int REG_W    = 32;               // every register
  localparam int ADDR_W   = 8;                // address byte leads the frame
  localparam int FRAME_W  = ADDR_W + REG_W;   // 40 bits, msb first
  localparam int BITCNT_W = 6;                // frame bit counter, saturates
  localparam int SEQ_W    = 6;                // azmux 3:0, precharge 5:4
  localparam int SEQ_MAX  = 4;                // sequence words
  localparam int STEP_W   = 2;                // step index and seq_n
  localparam int CNT_W    = 24;               // precharge and aperture counts

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;  // low byte of status

  ////////////////////////////////////////////////////////////////////////////
  // register addresses

  localparam logic [ADDR_W-1:0] ADDR_SPI_MUX   = 8'd1;
  localparam logic [ADDR_W-1:0] ADDR_4094      = 8'd2;   // bit 0 is oe
  localparam logic [ADDR_W-1:0] ADDR_MODE      = 8'd3;
  localparam logic [ADDR_W-1:0] ADDR_DIRECT    = 8'd4;
  localparam logic [ADDR_W-1:0] ADDR_STATUS    = 8'd5;   // read only
  localparam logic [ADDR_W-1:0] ADDR_PRECHARGE = 8'd6;
  localparam logic [ADDR_W-1:0] ADDR_SEQ_N     = 8'd7;
  localparam logic [ADDR_W-1:0] ADDR_SEQ0      = 8'd8;
  localparam logic [ADDR_W-1:0] ADDR_SEQ1      = 8'd9;
  localparam logic [ADDR_W-1:0] ADDR_SEQ2      = 8'd10;
  localparam logic [ADDR_W-1:0] ADDR_SEQ3      = 8'd11;
  localparam logic [ADDR_W-1:0] ADDR_APERTURE  = 8'd12;

  // one azmux/precharge word, and the full table
  typedef logic [SEQ_W-1:0]        seq_word_t;
  typedef seq_word_t [SEQ_MAX-1:0] seq_arr_t;

endpackage

`default_nettype wire

// File: dmm_out_pkg.sv
// mode codes, spi routing codes
// bit layout of the 25 bit control output vector
`default_nettype none

package dmm_out_pkg;

  localparam int OUT_W = 25;       // control outputs, meas complete on top

  ////////////////////////////////////////////////////////////////////////////
  // output vector fields, leds first since they are the most generic

  localparam int LEDS_LSB   = 0;
  localparam int LEDS_W     = 4;
  localparam int MON_LSB    = 4;
  localparam int MON_W      = 8;
  localparam int PC_LSB     = 12;   // precharge switches
  localparam int PC_W       = 2;
  localparam int AZ_LSB     = 14;
  localparam int AZ_W       = 4;
  localparam int REFMUX_LSB = 18;   // adc reference current mux
  localparam int REFMUX_W   = 4;
  localparam int LATCH_BIT  = 22;   // comparator latch
  localparam int INT_BIT    = 23;   // spi interrupt
  localparam int MEAS_BIT   = 24;   // measurement complete

  // modes, 4 5 and 7 fall through to all zeros
  localparam int MODE_W = 3;
  localparam logic [MODE_W-1:0] MODE_DIRECT   = 3'd0;
  localparam logic [MODE_W-1:0] MODE_LO       = 3'd1;
  localparam logic [MODE_W-1:0] MODE_HI       = 3'd2;
  localparam logic [MODE_W-1:0] MODE_PATTERN  = 3'd3;
  localparam logic [MODE_W-1:0] MODE_SEQ_MOCK = 3'd6;

  // shared spi bus owner
  localparam logic [1:0] SPI_MUX_PARK = 2'd0;   // clk and mosi held high
  localparam logic [1:0] SPI_MUX_4094 = 2'd1;   // cs2 strobes the 4094
  localparam logic [1:0] SPI_MUX_DAC  = 2'd2;   // cs2 selects the dac

endpackage

`default_nettype wire

// File: cfg_if.sv
// configuration interface from the register bank
// modports for the bank, the sequencer and the output mux
`timescale 1ns/100ps
`default_nettype none

interface cfg_if;

  logic [dmm_out_pkg::MODE_W-1:0]  mode;       // output source select
  logic [dmm_out_pkg::OUT_W-1:0]   direct;     // mode 0 value
  logic [dmm_reg_pkg::CNT_W-1:0]   precharge;  // clocks of adc reset per step
  logic [dmm_reg_pkg::STEP_W-1:0]  seq_n;      // last step index
  dmm_reg_pkg::seq_arr_t           seq;        // azmux/precharge words
  logic [dmm_reg_pkg::CNT_W-1:0]   aperture;   // mock adc integration clocks

  modport bank (
    output mode, direct, precharge, seq_n, seq, aperture
  );

  modport sequencer (
    input precharge, seq_n, seq
  );

  modport mux (
    input mode, direct
  );

endinterface

`default_nettype wire

// File: spi_reg_bank.sv
// spi slave register bank, sampled in the clk domain
// frame decode, register file, status readback, shared spi bus routing
`timescale 1ns/100ps
`default_nettype none

module spi_reg_bank (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       sck_i,
  input  logic       ss_i,          // active low
  input  logic       sdi_i,
  input  logic       spi_cs2_i,     // second select, routed by spi_mux
  input  logic [3:0] hw_flags_i,
  output logic       sdo_o,
  output logic       glb_spi_clk_o,
  output logic       glb_spi_mosi_o,
  output logic       glb_4094_strobe_o,
  output logic       spi_dac_ss_o,
  output logic       glb_4094_oe_o,
  cfg_if.bank        cfg
);

  ////////////////////////////////////////////////////////////////////////////
  // pin synchronizers, third stage only for edge detect

  logic [2:0] sck_q;
  logic [2:0] ss_q;
  logic [1:0] sdi_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sck_q <= '0;
      ss_q  <= '1;                    // deselected
      sdi_q <= '0;
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      ss_q  <= {ss_q[1:0], ss_i};
      sdi_q <= {sdi_q[0], sdi_i};
    end
  end

  logic sck_rise, sck_fall, ss_fall, ss_rise, sel;
  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign ss_fall  = ~ss_q[1] & ss_q[2];   // frame start
  assign ss_rise  = ss_q[1] & ~ss_q[2];   // frame end, commit point
  assign sel      = ~ss_q[1];

  ////////////////////////////////////////////////////////////////////////////
  // frame shifting

  logic [dmm_reg_pkg::FRAME_W-1:0]  rx;
  logic [dmm_reg_pkg::REG_W-1:0]    tx;        // readback shifter
  logic [dmm_reg_pkg::BITCNT_W-1:0] bit_cnt;
  logic [dmm_reg_pkg::REG_W-1:0]    rd_data;

  always_ff @(posedge clk) begin
    if (sel && sck_rise) rx <= {rx[dmm_reg_pkg::FRAME_W-2:0], sdi_q[1]};
  end

  always_ff @(posedge clk) begin
    if (rst_i || ss_fall || ss_rise) begin
      bit_cnt <= '0;
      tx      <= '0;
    end else if (sel) begin
      if (sck_rise && bit_cnt != '1) bit_cnt <= bit_cnt + 1'b1;   // saturate
      if (sck_fall) begin
        if (bit_cnt == dmm_reg_pkg::ADDR_W) tx <= rd_data;        // address done
        else if (bit_cnt > dmm_reg_pkg::ADDR_W) tx <= {tx[dmm_reg_pkg::REG_W-2:0], 1'b0};
      end
    end
  end

  assign sdo_o = tx[dmm_reg_pkg::REG_W-1];

  ////////////////////////////////////////////////////////////////////////////
  // register file

  logic [dmm_reg_pkg::REG_W-1:0]  reg_spi_mux, reg_4094, reg_mode, reg_direct;
  logic [dmm_reg_pkg::REG_W-1:0]  reg_precharge, reg_aperture;
  logic [dmm_reg_pkg::STEP_W-1:0] reg_seq_n;
  dmm_reg_pkg::seq_arr_t          reg_seq;

  logic [dmm_reg_pkg::ADDR_W-1:0] wr_addr;
  logic [dmm_reg_pkg::REG_W-1:0]  wr_data;
  logic                           commit;

  assign wr_addr = rx[dmm_reg_pkg::FRAME_W-1 -: dmm_reg_pkg::ADDR_W];
  assign wr_data = rx[dmm_reg_pkg::REG_W-1:0];
  // short or long frames are dropped, status is never written
  assign commit  = ss_rise && bit_cnt == dmm_reg_pkg::FRAME_W &&
                   wr_addr != dmm_reg_pkg::ADDR_STATUS;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      reg_spi_mux   <= '0;          // parked
      reg_4094      <= '0;          // 4094 outputs not enabled at start up
      reg_mode      <= '0;
      reg_direct    <= '0;
      reg_precharge <= '0;
      reg_aperture  <= '0;
      reg_seq_n     <= '0;
      reg_seq       <= '0;
    end else if (commit) begin
      case (wr_addr)
        dmm_reg_pkg::ADDR_SPI_MUX:   reg_spi_mux   <= wr_data;
        dmm_reg_pkg::ADDR_4094:      reg_4094      <= wr_data;
        dmm_reg_pkg::ADDR_MODE:      reg_mode      <= wr_data;
        dmm_reg_pkg::ADDR_DIRECT:    reg_direct    <= wr_data;
        dmm_reg_pkg::ADDR_PRECHARGE: reg_precharge <= wr_data;
        dmm_reg_pkg::ADDR_SEQ_N:     reg_seq_n     <= wr_data[dmm_reg_pkg::STEP_W-1:0];
        dmm_reg_pkg::ADDR_SEQ0:      reg_seq[0]    <= wr_data[dmm_reg_pkg::SEQ_W-1:0];
        dmm_reg_pkg::ADDR_SEQ1:      reg_seq[1]    <= wr_data[dmm_reg_pkg::SEQ_W-1:0];
        dmm_reg_pkg::ADDR_SEQ2:      reg_seq[2]    <= wr_data[dmm_reg_pkg::SEQ_W-1:0];
        dmm_reg_pkg::ADDR_SEQ3:      reg_seq[3]    <= wr_data[dmm_reg_pkg::SEQ_W-1:0];
        dmm_reg_pkg::ADDR_APERTURE:  reg_aperture  <= wr_data;
        default: ;                    // unmapped address
      endcase
    end
  end

  // readback, address is the low byte of rx once 8 bits are in
  always_comb begin
    case (rx[dmm_reg_pkg::ADDR_W-1:0])
      dmm_reg_pkg::ADDR_SPI_MUX:   rd_data = reg_spi_mux;
      dmm_reg_pkg::ADDR_4094:      rd_data = reg_4094;
      dmm_reg_pkg::ADDR_MODE:      rd_data = reg_mode;
      dmm_reg_pkg::ADDR_DIRECT:    rd_data = reg_direct;
      dmm_reg_pkg::ADDR_STATUS:    rd_data = {20'b0, hw_flags_i, dmm_reg_pkg::STATUS_MAGIC};
      dmm_reg_pkg::ADDR_PRECHARGE: rd_data = reg_precharge;
      dmm_reg_pkg::ADDR_SEQ_N:     rd_data = dmm_reg_pkg::REG_W'(reg_seq_n);
      dmm_reg_pkg::ADDR_SEQ0:      rd_data = dmm_reg_pkg::REG_W'(reg_seq[0]);
      dmm_reg_pkg::ADDR_SEQ1:      rd_data = dmm_reg_pkg::REG_W'(reg_seq[1]);
      dmm_reg_pkg::ADDR_SEQ2:      rd_data = dmm_reg_pkg::REG_W'(reg_seq[2]);
      dmm_reg_pkg::ADDR_SEQ3:      rd_data = dmm_reg_pkg::REG_W'(reg_seq[3]);
      dmm_reg_pkg::ADDR_APERTURE:  rd_data = reg_aperture;
      default:                     rd_data = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // shared bus routing, raw pins gated by the registered owner

  assign glb_spi_clk_o     = (reg_spi_mux == 32'(dmm_out_pkg::SPI_MUX_PARK)) ? 1'b1 : sck_i;
  assign glb_spi_mosi_o    = (reg_spi_mux == 32'(dmm_out_pkg::SPI_MUX_PARK)) ? 1'b1 : sdi_i;
  assign glb_4094_strobe_o = (reg_spi_mux == 32'(dmm_out_pkg::SPI_MUX_4094)) ? ~spi_cs2_i : 1'b0;
  assign spi_dac_ss_o      = (reg_spi_mux == 32'(dmm_out_pkg::SPI_MUX_DAC)) ? spi_cs2_i : 1'b1;
  assign glb_4094_oe_o     = reg_4094[0];

  assign cfg.mode      = reg_mode[dmm_out_pkg::MODE_W-1:0];
  assign cfg.direct    = reg_direct[dmm_out_pkg::OUT_W-1:0];
  assign cfg.precharge = reg_precharge[dmm_reg_pkg::CNT_W-1:0];
  assign cfg.aperture  = reg_aperture[dmm_reg_pkg::CNT_W-1:0];
  assign cfg.seq_n     = reg_seq_n;
  assign cfg.seq       = reg_seq;

endmodule

`default_nettype wire

// File: acq_sequencer.sv
// acquisition sequencer
// steps azmux and precharge words around adc conversions
`timescale 1ns/100ps
`default_nettype none

module acq_sequencer (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            trig_i,          // level, low holds idle
  input  logic                            measure_valid_i, // end of conversion
  cfg_if.sequencer                        cfg,
  output logic                            adc_reset_n_o,
  output logic [dmm_out_pkg::AZ_W-1:0]    azmux_o,
  output logic [dmm_out_pkg::PC_W-1:0]    pc_sw_o,
  output logic [dmm_out_pkg::MON_W-1:0]   monitor_o,
  output logic [dmm_out_pkg::LEDS_W-1:0]  leds_o
);

  logic [dmm_reg_pkg::CNT_W-1:0]  pc_cnt;   // precharge clocks so far
  logic [dmm_reg_pkg::STEP_W-1:0] step;
  dmm_reg_pkg::seq_word_t         word;

  ////////////////////////////////////////////////////////////////////////////
  // step control
  // adc held in reset for precharge + 1 clocks, then released until
  // the adc reports a result

  always_ff @(posedge clk) begin
    if (rst_i || !trig_i) begin
      pc_cnt        <= '0;
      step          <= '0;
      adc_reset_n_o <= 1'b0;
    end else if (!adc_reset_n_o) begin
      if (pc_cnt == cfg.precharge) begin
        adc_reset_n_o <= 1'b1;        // start conversion
      end else begin
        pc_cnt <= pc_cnt + 1'b1;
      end
    end else if (measure_valid_i) begin
      adc_reset_n_o <= 1'b0;          // back to precharge for the next word
      pc_cnt        <= '0;
      if (step == cfg.seq_n) step <= '0;   // wrap after the last word
      else                   step <= step + 1'b1;
    end
  end

  // current word drives the switches
  assign word    = cfg.seq[step];
  assign azmux_o = word[dmm_out_pkg::AZ_W-1:0];
  assign pc_sw_o = word[dmm_reg_pkg::SEQ_W-1 -: dmm_out_pkg::PC_W];

  // monitor, for a scope on the header pins
  assign monitor_o = {4'b0, step, measure_valid_i, adc_reset_n_o};

  assign leds_o = dmm_out_pkg::LEDS_W'(1) << step;   // one hot step

endmodule

`default_nettype wire

// File: adc_mock.sv
// mock adc, counts an aperture and pulses measure valid
`timescale 1ns/100ps
`default_nettype none

module adc_mock (
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic                          reset_n_i,    // low holds and re-arms
  input  logic [dmm_reg_pkg::CNT_W-1:0] aperture_i,
  output logic                          measure_valid_o
);

  logic [dmm_reg_pkg::CNT_W-1:0] cnt;
  logic                          done;   // result given, wait for reset

  always_ff @(posedge clk) begin
    if (rst_i || !reset_n_i) begin
      cnt             <= '0;
      done            <= 1'b0;
      measure_valid_o <= 1'b0;
    end else begin
      measure_valid_o <= 1'b0;          // single clock pulse
      if (!done) begin
        if (cnt == aperture_i) begin
          measure_valid_o <= 1'b1;      // aperture + 1 clocks after release
          done            <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: mode_out_mux.sv
// test pattern counter
// registered mode selection of the control output vector
`timescale 1ns/100ps
`default_nettype none

module mode_out_mux (
  input  logic                            clk,
  input  logic                            rst_i,
  cfg_if.mux                              cfg,
  input  logic [dmm_out_pkg::AZ_W-1:0]    seq_azmux_i,
  input  logic [dmm_out_pkg::PC_W-1:0]    seq_pc_i,
  input  logic [dmm_out_pkg::MON_W-1:0]   seq_mon_i,
  input  logic [dmm_out_pkg::LEDS_W-1:0]  seq_leds_i,
  output logic [dmm_out_pkg::OUT_W-1:0]   ctl_o
);

  logic [dmm_out_pkg::OUT_W-1:0] pattern;   // free running, leds count in mode 3
  logic [dmm_out_pkg::OUT_W-1:0] seq_vec;

  always_ff @(posedge clk) begin
    if (rst_i) pattern <= '0;
    else       pattern <= pattern + 1'b1;
  end

  // mode 6 vector, refmux latch int and meas complete stay low
  always_comb begin
    seq_vec = '0;
    seq_vec[dmm_out_pkg::LEDS_LSB +: dmm_out_pkg::LEDS_W] = seq_leds_i;
    seq_vec[dmm_out_pkg::MON_LSB  +: dmm_out_pkg::MON_W]  = seq_mon_i;
    seq_vec[dmm_out_pkg::PC_LSB   +: dmm_out_pkg::PC_W]   = seq_pc_i;
    seq_vec[dmm_out_pkg::AZ_LSB   +: dmm_out_pkg::AZ_W]   = seq_azmux_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ctl_o <= '0;                    // everything low out of reset
    end else begin
      case (cfg.mode)
        dmm_out_pkg::MODE_DIRECT:   ctl_o <= cfg.direct;
        dmm_out_pkg::MODE_LO:       ctl_o <= '0;
        dmm_out_pkg::MODE_HI:       ctl_o <= '1;
        dmm_out_pkg::MODE_PATTERN:  ctl_o <= pattern;
        dmm_out_pkg::MODE_SEQ_MOCK: ctl_o <= seq_vec;
        default:                    ctl_o <= '0;   // modes 4 5 7
      endcase
    end
  end

endmodule

`default_nettype wire

// File: dmm_top.sv
// dmm front-end controller top level
// register bank, sequencer with mock adc, output mode mux
`timescale 1ns/100ps
`default_nettype none

module dmm_top (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            SCK,
  input  logic                            SS,
  input  logic                            SDI,
  input  logic                            SPI_CS2,
  input  logic                            U1004_4094_DATA,            // unused
  input  logic [3:0]                      hw_flags_i,
  input  logic                            trigger_source_internal_i,
  input  logic                            trigger_source_external_i,  // unused
  input  logic                            adc_cmpr_p_i,               // unused
  output logic                            SDO,
  output logic                            GLB_SPI_CLK,
  output logic                            GLB_SPI_MOSI,
  output logic                            GLB_4094_OE_CTL,
  output logic                            GLB_4094_STROBE_CTL,
  output logic                            SPI_DAC_SS,
  output logic [dmm_out_pkg::LEDS_W-1:0]  leds_o,
  output logic [dmm_out_pkg::MON_W-1:0]   monitor_o,
  output logic [dmm_out_pkg::PC_W-1:0]    pc_sw_o,
  output logic [dmm_out_pkg::AZ_W-1:0]    azmux_o,
  output logic [dmm_out_pkg::REFMUX_W-1:0] adc_refmux_o,
  output logic                            adc_cmpr_latch_ctl_o,
  output logic                            spi_interrupt_ctl_o,
  output logic                            meas_complete_o
);

  cfg_if cfg ();

  logic                            adc_reset_n, measure_valid;
  logic [dmm_out_pkg::AZ_W-1:0]    seq_azmux;
  logic [dmm_out_pkg::PC_W-1:0]    seq_pc;
  logic [dmm_out_pkg::MON_W-1:0]   seq_mon;
  logic [dmm_out_pkg::LEDS_W-1:0]  seq_leds;
  logic [dmm_out_pkg::OUT_W-1:0]   ctl;

  spi_reg_bank u_bank (
    .clk(clk), .rst_i(rst_i),
    .sck_i(SCK), .ss_i(SS), .sdi_i(SDI), .spi_cs2_i(SPI_CS2),
    .hw_flags_i(hw_flags_i),
    .sdo_o(SDO), .glb_spi_clk_o(GLB_SPI_CLK), .glb_spi_mosi_o(GLB_SPI_MOSI),
    .glb_4094_strobe_o(GLB_4094_STROBE_CTL), .spi_dac_ss_o(SPI_DAC_SS),
    .glb_4094_oe_o(GLB_4094_OE_CTL),
    .cfg(cfg.bank)
  );

  acq_sequencer u_seq (
    .clk(clk), .rst_i(rst_i),
    .trig_i(trigger_source_internal_i), .measure_valid_i(measure_valid),
    .cfg(cfg.sequencer),
    .adc_reset_n_o(adc_reset_n), .azmux_o(seq_azmux), .pc_sw_o(seq_pc),
    .monitor_o(seq_mon), .leds_o(seq_leds)
  );

  adc_mock u_adc (
    .clk(clk), .rst_i(rst_i),
    .reset_n_i(adc_reset_n), .aperture_i(cfg.aperture),
    .measure_valid_o(measure_valid)
  );

  mode_out_mux u_mux (
    .clk(clk), .rst_i(rst_i), .cfg(cfg.mux),
    .seq_azmux_i(seq_azmux), .seq_pc_i(seq_pc), .seq_mon_i(seq_mon),
    .seq_leds_i(seq_leds), .ctl_o(ctl)
  );

  // split the control vector onto the pins
  assign leds_o               = ctl[dmm_out_pkg::LEDS_LSB +: dmm_out_pkg::LEDS_W];
  assign monitor_o            = ctl[dmm_out_pkg::MON_LSB +: dmm_out_pkg::MON_W];
  assign pc_sw_o              = ctl[dmm_out_pkg::PC_LSB +: dmm_out_pkg::PC_W];
  assign azmux_o              = ctl[dmm_out_pkg::AZ_LSB +: dmm_out_pkg::AZ_W];
  assign adc_refmux_o         = ctl[dmm_out_pkg::REFMUX_LSB +: dmm_out_pkg::REFMUX_W];
  assign adc_cmpr_latch_ctl_o = ctl[dmm_out_pkg::LATCH_BIT];
  assign spi_interrupt_ctl_o  = ctl[dmm_out_pkg::INT_BIT];
  assign meas_complete_o      = ctl[dmm_out_pkg::MEAS_BIT];

endmodule

`default_nettype wire

// File: tb_dmm_chk.sv
// bound checker for dmm_top
// reset state, shared spi bus routing, 4094 oe and the constant output modes
`timescale 1ns/100ps
`default_nettype none

module tb_dmm_chk (
  input wire logic                          clk,
  input wire logic                          rst_i,
  input wire logic [dmm_out_pkg::MODE_W-1:0] mode_i,
  input wire logic [dmm_reg_pkg::REG_W-1:0] spi_mux_i,   // raw owner register
  input wire logic                          commit_i,    // frame accepted
  input wire logic [dmm_reg_pkg::ADDR_W-1:0] wr_addr_i,  // address of that frame
  input wire logic                          wr_bit0_i,   // data bit 0 of that frame
  input wire logic [dmm_out_pkg::OUT_W-1:0] ctl_i,       // registered control vector
  input wire logic                          sck_i,
  input wire logic                          sdi_i,
  input wire logic                          cs2_i,
  input wire logic                          sdo_i,
  input wire logic                          spi_clk_i,
  input wire logic                          mosi_i,
  input wire logic                          strobe_i,
  input wire logic                          dac_ss_i,
  input wire logic                          oe_i
);

  int unsigned fails = 0;   // watched by the testbench top

  ////////////////////////////////////////////////////////////////////////////
  // reset state, one clock after rst_i is seen

  a_reset : assert property (@(posedge clk) rst_i |=> (ctl_i == '0 && !oe_i && spi_clk_i &&
                                                       mosi_i && dac_ss_i && !strobe_i && !sdo_i))
    else begin
      fails++;
      $error("outputs not in their reset state");
    end

  ////////////////////////////////////////////////////////////////////////////
  // shared bus routing, combinational from the pins

  a_park : assert property (@(posedge clk)
      spi_mux_i == 32'(dmm_out_pkg::SPI_MUX_PARK) |-> (spi_clk_i && mosi_i && dac_ss_i && !strobe_i))
    else begin
      fails++;
      $error("parked bus not held idle");
    end

  a_4094 : assert property (@(posedge clk)
      spi_mux_i == 32'(dmm_out_pkg::SPI_MUX_4094) |->
        (spi_clk_i == sck_i && mosi_i == sdi_i && strobe_i == !cs2_i && dac_ss_i))
    else begin
      fails++;
      $error("4094 routing wrong");
    end

  a_dac : assert property (@(posedge clk)
      spi_mux_i == 32'(dmm_out_pkg::SPI_MUX_DAC) |->
        (spi_clk_i == sck_i && mosi_i == sdi_i && !strobe_i && dac_ss_i == cs2_i))
    else begin
      fails++;
      $error("dac routing wrong");
    end

  // oe takes bit 0 of a frame written to the 4094 address, one clock later
  a_oe_set : assert property (@(posedge clk)
      !rst_i && commit_i && wr_addr_i == dmm_reg_pkg::ADDR_4094 |=> oe_i == $past(wr_bit0_i))
    else begin
      fails++;
      $error("4094 oe does not take the written bit");
    end

  a_oe_hold : assert property (@(posedge clk)
      !rst_i && !(commit_i && wr_addr_i == dmm_reg_pkg::ADDR_4094) |=> $stable(oe_i))
    else begin
      fails++;
      $error("4094 oe changed without a write to its register");
    end

  ////////////////////////////////////////////////////////////////////////////
  // constant modes, output register lags the mode by one clock

  a_lo : assert property (@(posedge clk)
      !rst_i && mode_i == dmm_out_pkg::MODE_LO |=> ctl_i == '0)
    else begin
      fails++;
      $error("mode 1 output not all low");
    end

  a_unused : assert property (@(posedge clk) !rst_i && mode_i == 3'd4 |=> ctl_i == '0)  // dropped mode
    else begin
      fails++;
      $error("mode 4 output not all low");
    end

  a_hi : assert property (@(posedge clk)
      !rst_i && mode_i == dmm_out_pkg::MODE_HI |=> ctl_i == '1)
    else begin
      fails++;
      $error("mode 2 output not all high");
    end

endmodule

`default_nettype wire

// File: tb_dmm.sv
// testbench for dmm_top
// clock and reset, spi frame tasks, register readback, mode and sequencer checks
`timescale 1ns/100ps
`default_nettype none

module tb_dmm;

  logic clk, rst_i, sck, ss, sdi, cs2, u1004_data, trig_int, trig_ext, cmpr_p;
  logic [3:0] hw_flags;
  logic sdo, glb_spi_clk, glb_spi_mosi, oe_ctl, strobe_ctl, dac_ss;
  logic [dmm_out_pkg::LEDS_W-1:0]   leds_o;
  logic [dmm_out_pkg::MON_W-1:0]    monitor_o;
  logic [dmm_out_pkg::PC_W-1:0]     pc_sw_o;
  logic [dmm_out_pkg::AZ_W-1:0]     azmux_o;
  logic [dmm_out_pkg::REFMUX_W-1:0] refmux_o;
  logic latch_o, int_o, meas_o;

  logic [31:0] rd, exp_direct, exp_pre, exp_ap, exp_sn;
  logic [31:0] seq_raw [4];       // words as written, upper bits dropped by the dut
  logic [3:0]  leds_prev;
  logic [1:0]  prev_step, cur_step, exp_step;
  int          visits, run, pre, ap, sn, i;
  integer      seed;

  dmm_top uut (
    .clk(clk), .rst_i(rst_i), .SCK(sck), .SS(ss), .SDI(sdi), .SPI_CS2(cs2),
    .U1004_4094_DATA(u1004_data), .hw_flags_i(hw_flags),
    .trigger_source_internal_i(trig_int), .trigger_source_external_i(trig_ext),
    .adc_cmpr_p_i(cmpr_p),
    .SDO(sdo), .GLB_SPI_CLK(glb_spi_clk), .GLB_SPI_MOSI(glb_spi_mosi),
    .GLB_4094_OE_CTL(oe_ctl), .GLB_4094_STROBE_CTL(strobe_ctl), .SPI_DAC_SS(dac_ss),
    .leds_o(leds_o), .monitor_o(monitor_o), .pc_sw_o(pc_sw_o), .azmux_o(azmux_o),
    .adc_refmux_o(refmux_o), .adc_cmpr_latch_ctl_o(latch_o),
    .spi_interrupt_ctl_o(int_o), .meas_complete_o(meas_o)
  );

  bind dmm_top tb_dmm_chk chk (
    .clk(clk), .rst_i(rst_i), .mode_i(cfg.mode), .spi_mux_i(u_bank.reg_spi_mux),
    .commit_i(u_bank.commit), .wr_addr_i(u_bank.wr_addr),
    .wr_bit0_i(u_bank.wr_data[0]), .ctl_i(ctl),
    .sck_i(SCK), .sdi_i(SDI), .cs2_i(SPI_CS2), .sdo_i(SDO),
    .spi_clk_i(GLB_SPI_CLK), .mosi_i(GLB_SPI_MOSI), .strobe_i(GLB_4094_STROBE_CTL),
    .dac_ss_i(SPI_DAC_SS), .oe_i(GLB_4094_OE_CTL)
  );

  always #50 clk = ~clk;   // 100 ns period

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else
      abort_run($sformatf("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp));
  endtask

  task automatic tick(input int n);
    repeat (n) @(posedge clk);
  endtask

  // mode 0 spi, sck 4 clocks per phase, sdo sampled just before each rise
  task automatic spi_frame(input logic [7:0] addr, input logic [31:0] data,
                           input int nbits, output logic [31:0] rdata);
    logic [dmm_reg_pkg::FRAME_W-1:0] frame;
    int k;
    frame = {addr, data};
    rdata = '0;
    tick(4);                                  // ss idle gap
    ss <= 1'b0;
    tick(4);
    for (k = 0; k < nbits; k++) begin
      sdi <= (k < dmm_reg_pkg::FRAME_W) ? frame[dmm_reg_pkg::FRAME_W-1-k] : 1'b0;
      tick(3);
      @(negedge clk);
      if (k >= dmm_reg_pkg::ADDR_W && k < dmm_reg_pkg::FRAME_W)
        rdata = {rdata[30:0], sdo};           // data phase only
      @(posedge clk);
      sck <= 1'b1;
      tick(4);
      sck <= 1'b0;
    end
    tick(4);
    ss <= 1'b1;                               // commit point for 40 bit frames
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    spi_frame(addr, data, dmm_reg_pkg::FRAME_W, unused);
  endtask

  // one extra bit so the frame is dropped and nothing gets written
  task automatic read_reg(input logic [7:0] addr, output logic [31:0] rdata);
    spi_frame(addr, 32'h0, dmm_reg_pkg::FRAME_W + 1, rdata);
  endtask

  task automatic pulse_cs2();
    @(posedge clk);
    cs2 <= 1'b0;
    tick(3);
    cs2 <= 1'b1;
    tick(3);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    seed = 32'h902a_413c;
    clk = 1'b0;
    rst_i = 1'b1;
    sck = 1'b0;
    ss = 1'b1;
    sdi = 1'b0;
    cs2 = 1'b1;                               // second select idles high
    u1004_data = 1'b0;
    trig_int = 1'b0;
    trig_ext = 1'b0;
    cmpr_p = 1'b0;
    hw_flags = 4'($random(seed));
    tick(8);
    rst_i <= 1'b0;

    // register readback
    exp_direct = $random(seed);
    write_reg(dmm_reg_pkg::ADDR_DIRECT, exp_direct);
    exp_pre = $random(seed);
    write_reg(dmm_reg_pkg::ADDR_PRECHARGE, exp_pre);
    exp_ap = $random(seed);
    write_reg(dmm_reg_pkg::ADDR_APERTURE, exp_ap);
    exp_sn = $random(seed);
    write_reg(dmm_reg_pkg::ADDR_SEQ_N, exp_sn);
    for (i = 0; i < 4; i++) begin
      seq_raw[i] = $random(seed);
      write_reg(8'(dmm_reg_pkg::ADDR_SEQ0 + i), seq_raw[i]);
    end
    read_reg(dmm_reg_pkg::ADDR_DIRECT, rd);
    check_val("direct", rd, exp_direct);
    read_reg(dmm_reg_pkg::ADDR_PRECHARGE, rd);
    check_val("precharge", rd, exp_pre);
    read_reg(dmm_reg_pkg::ADDR_APERTURE, rd);
    check_val("aperture", rd, exp_ap);
    read_reg(dmm_reg_pkg::ADDR_SEQ_N, rd);
    check_val("seq_n", rd, {30'b0, exp_sn[1:0]});
    for (i = 0; i < 4; i++) begin
      read_reg(8'(dmm_reg_pkg::ADDR_SEQ0 + i), rd);
      check_val($sformatf("seq%0d", i), rd, {26'b0, seq_raw[i][5:0]});
    end
    read_reg(dmm_reg_pkg::ADDR_STATUS, rd);
    check_val("status", rd, {20'b0, hw_flags, 8'hAA});   // flags over magic byte

    // mode 0, direct value split onto the pins
    exp_direct = $random(seed);
    write_reg(dmm_reg_pkg::ADDR_DIRECT, exp_direct);
    tick(5);
    @(negedge clk);
    check_val("leds_o", leds_o, exp_direct[dmm_out_pkg::LEDS_LSB +: dmm_out_pkg::LEDS_W]);
    check_val("monitor_o", monitor_o, exp_direct[dmm_out_pkg::MON_LSB +: dmm_out_pkg::MON_W]);
    check_val("pc_sw_o", pc_sw_o, exp_direct[dmm_out_pkg::PC_LSB +: dmm_out_pkg::PC_W]);
    check_val("azmux_o", azmux_o, exp_direct[dmm_out_pkg::AZ_LSB +: dmm_out_pkg::AZ_W]);
    check_val("adc_refmux_o", refmux_o,
              exp_direct[dmm_out_pkg::REFMUX_LSB +: dmm_out_pkg::REFMUX_W]);
    check_val("adc_cmpr_latch_ctl_o", latch_o, exp_direct[dmm_out_pkg::LATCH_BIT]);
    check_val("spi_interrupt_ctl_o", int_o, exp_direct[dmm_out_pkg::INT_BIT]);
    check_val("meas_complete_o", meas_o, exp_direct[dmm_out_pkg::MEAS_BIT]);

    // constant modes and bus routing, judged by the bound checker
    write_reg(dmm_reg_pkg::ADDR_MODE, 32'(dmm_out_pkg::MODE_LO));
    tick(8);
    write_reg(dmm_reg_pkg::ADDR_MODE, 32'd4);
    tick(8);
    write_reg(dmm_reg_pkg::ADDR_MODE, 32'(dmm_out_pkg::MODE_HI));
    tick(8);
    pulse_cs2();                              // parked
    write_reg(dmm_reg_pkg::ADDR_4094, 32'd1);
    write_reg(dmm_reg_pkg::ADDR_SPI_MUX, 32'(dmm_out_pkg::SPI_MUX_4094));
    pulse_cs2();
    read_reg(dmm_reg_pkg::ADDR_MODE, rd);     // sck and sdi pass through
    check_val("mode", rd, 32'(dmm_out_pkg::MODE_HI));
    write_reg(dmm_reg_pkg::ADDR_SPI_MUX, 32'(dmm_out_pkg::SPI_MUX_DAC));
    pulse_cs2();
    read_reg(dmm_reg_pkg::ADDR_4094, rd);
    check_val("4094", rd, 32'd1);
    write_reg(dmm_reg_pkg::ADDR_SPI_MUX, 32'(dmm_out_pkg::SPI_MUX_PARK));
    write_reg(dmm_reg_pkg::ADDR_4094, 32'd0);

    // mode 3, leds are the low bits of a free running count
    write_reg(dmm_reg_pkg::ADDR_MODE, 32'(dmm_out_pkg::MODE_PATTERN));
    tick(5);
    @(negedge clk);
    leds_prev = leds_o;
    repeat (40) begin
      @(negedge clk);
      check_val("leds_o", leds_o, 4'(leds_prev + 4'd1));
      leds_prev = leds_o;
    end

    ////////////////////////////////////////////////////////////////////////////
    // mode 6, sequencer with the mock adc
    pre = {$random(seed)} % 8;
    ap  = {$random(seed)} % 8;
    sn  = {$random(seed)} % 3 + 1;            // at least two steps so the index moves
    write_reg(dmm_reg_pkg::ADDR_PRECHARGE, 32'(pre));
    write_reg(dmm_reg_pkg::ADDR_APERTURE, 32'(ap));
    write_reg(dmm_reg_pkg::ADDR_SEQ_N, 32'(sn));
    for (i = 0; i < 4; i++) begin
      seq_raw[i] = $random(seed);
      write_reg(8'(dmm_reg_pkg::ADDR_SEQ0 + i), seq_raw[i]);
    end
    write_reg(dmm_reg_pkg::ADDR_MODE, 32'(dmm_out_pkg::MODE_SEQ_MOCK));
    tick(5);
    @(posedge clk);
    trig_int <= 1'b1;
    visits = 0;
    run = 0;
    prev_step = 2'd0;
    while (visits < 2 * (sn + 1) + 1) begin  // past the wrap once
      @(negedge clk);
      cur_step = monitor_o[3:2];              // step index on the monitor pins
      if (cur_step != prev_step) begin
        exp_step = (prev_step == 2'(sn)) ? 2'd0 : prev_step + 2'd1;
        check_val("step", cur_step, exp_step);
        if (visits > 0) begin
          assert (run >= pre + ap + 2) else
            abort_run($sformatf("azmux of step %0d held only %0d clocks", prev_step, run));
        end
        visits++;
        run = 0;
        prev_step = cur_step;
      end
      run++;
      check_val("azmux_o", azmux_o, seq_raw[cur_step][3:0]);
      check_val("pc_sw_o", pc_sw_o, seq_raw[cur_step][5:4]);
      check_val("leds_o", leds_o, 4'b0001 << cur_step);   // one hot step
    end
    @(posedge clk);
    trig_int <= 1'b0;
    tick(4);

    if (uut.chk.fails == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      abort_run("the bound checker reported assertion failures");
    end
  end

  // checker failures end the run at once
  always @(uut.chk.fails) begin
    if (uut.chk.fails != 0)
      abort_run("a bound assertion in the checker failed");
  end

  // about 48 frames, the sequencer run and some idle clocks
  initial begin : watchdog
    int frame_cycles;
    int seq_cycles;
    frame_cycles = (dmm_reg_pkg::FRAME_W + 1) * 8 + 16;
    seq_cycles   = 10 * (7 + 7 + 3);          // nine steps at most, each short
    #((48 * frame_cycles + seq_cycles + 400) * 100);
    abort_run("timeout, the test sequence did not finish in time");
  end

endmodule

`default_nettype wire

// File: files.f
dmm_reg_pkg.sv
dmm_out_pkg.sv
cfg_if.sv
spi_reg_bank.sv
acq_sequencer.sv
adc_mock.sv
mode_out_mux.sv
dmm_top.sv
tb_dmm_chk.sv
tb_dmm.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_dmm
FILELIST  := files.f
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing --assert -Wall
RUNFLAGS  := +verilator+error+limit+100
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
